// ==== tb.f ====
fifo_cfg_pkg.sv
fifo_types_pkg.sv
async_fifo.sv
ingress_dispatch.sv
egress_merge.sv
cdc_collector_top.sv
tb_cdc_collector.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the collector testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tb.f \
    --top-module tb_cdc_collector \
    -o sim_cdc_collector

out=$(./obj_dir/sim_cdc_collector 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// ==== tb_cdc_collector.sv ====
`default_nettype none

module tb_cdc_collector;

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    localparam int NUM_ROWS     = 11;
    localparam int RANDOM_CH    = -1;
    // longest rd_clk wait for a pending sample through the synchronisers and one round-robin pass
    localparam int STARVE_LIMIT = 12;

    // stimulus rows with channel (-1 picks one per strobe), burst, drain_en and idle wr_clk cycles
    localparam int ROW_CH    [NUM_ROWS] = '{0, 3, 1, 1, 2, 2, 2, -1, -1, -1, -1};
    localparam int ROW_BURST [NUM_ROWS] = '{6, 4, 18, 0, 2, 3, 0, 60, 30, 0, 24};
    localparam int ROW_DRAIN [NUM_ROWS] = '{1, 1, 0, 1, 0, 0, 1, 1, 0, 1, 1};
    localparam int ROW_IDLE  [NUM_ROWS] = '{12, 12, 12, 12, 12, 12, 12, 16, 12, 16, 16};

    logic                     wr_clk;
    logic                     rd_clk;
    logic                     rst_n;
    logic                     in_valid;
    ch_t                      in_ch;
    logic [DATA_W-1:0]        in_data;
    logic                     drain_en;
    logic                     out_valid;
    ch_t                      out_ch;
    logic [DATA_W-1:0]        out_data;
    logic [NUM_CH*DROP_W-1:0] drop_count;
    logic [NUM_CH-1:0]        ch_empty;
    logic [NUM_CH-1:0]        ch_almost_full;
    logic [NUM_CH-1:0]        ch_almost_empty;

    // accepted samples per channel, pushed by the driver only
    logic [DATA_W-1:0] model_q [NUM_CH][$];
    int acc_cnt  [NUM_CH];
    int drop_cnt [NUM_CH];
    int errors_main;

    // owned by the output monitor
    int rd_idx   [NUM_CH];
    int wait_cnt [NUM_CH];
    int out_total;
    int errors_mon;
    logic prev_valid;
    ch_t  prev_ch;

    int cycles = 0;
    int cycle_limit;

    cdc_collector_top cdc_collector_top_i (
        .wr_clk          (wr_clk),
        .rd_clk          (rd_clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ch           (in_ch),
        .in_data         (in_data),
        .drain_en        (drain_en),
        .out_valid       (out_valid),
        .out_ch          (out_ch),
        .out_data        (out_data),
        .drop_count      (drop_count),
        .ch_empty        (ch_empty),
        .ch_almost_full  (ch_almost_full),
        .ch_almost_empty (ch_almost_empty)
    );

    initial begin
        rd_clk = 1'b0;
        forever #4 rd_clk = ~rd_clk;
    end

    // 11 unit period
    initial begin
        wr_clk = 1'b0;
        forever begin
            #6 wr_clk = 1'b1;
            #5 wr_clk = 1'b0;
        end
    end

    function automatic bit check_eq(input string name, input int exp_v, input int got_v);
        bit bad;
        bad = 1'b0;
        assert (exp_v == got_v) else begin
            $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, exp_v, got_v);
            bad = 1'b1;
        end
        return bad;
    endfunction

    function automatic int pending(input int c);
        return model_q[c].size() - rd_idx[c];
    endfunction

    function automatic int pending_total();
        int sum;
        sum = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            sum += pending(c);
        end
        return sum;
    endfunction

    function automatic int sum_of(input int v [NUM_CH]);
        int sum;
        sum = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            sum += v[c];
        end
        return sum;
    endfunction

    function automatic int timeout_limit();
        int len;
        len = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            len += ROW_BURST[r] * 2 + ROW_IDLE[r];
        end
        return len * 4 + 200;
    endfunction

    // strobe lasts one wr_clk cycle, then one idle cycle
    task automatic send_strobe(input int c, input logic [DATA_W-1:0] d);
        @(posedge wr_clk);
        in_valid <= 1'b1;
        in_ch    <= ch_t'(c);
        in_data  <= d;
        if (pending(c) < FIFO_DEPTH - 1) begin
            model_q[c].push_back(d);
            acc_cnt[c]++;
        end else if (drop_cnt[c] < (1 << DROP_W) - 1) begin
            drop_cnt[c]++;
        end
        @(posedge wr_clk);
        in_valid <= 1'b0;
    endtask

    // flags against the model fill once the synchronisers have settled
    task automatic check_flags();
        int fill;
        @(posedge rd_clk);
        for (int c = 0; c < NUM_CH; c++) begin
            fill = pending(c);
            errors_main += int'(check_eq($sformatf("ch_empty[%0d]", c),
                                         int'(fill == 0), int'(ch_empty[c])));
            errors_main += int'(check_eq($sformatf("ch_almost_empty[%0d]", c),
                                         int'(fill <= ALMOST_EMPTY_THRESH),
                                         int'(ch_almost_empty[c])));
            errors_main += int'(check_eq($sformatf("ch_almost_full[%0d]", c),
                                         int'(fill >= ALMOST_FULL_THRESH),
                                         int'(ch_almost_full[c])));
            errors_main += int'(check_eq($sformatf("drop_count[%0d]", c), drop_cnt[c],
                                         int'(drop_count[c*DROP_W +: DROP_W])));
        end
    endtask

    task automatic run_row(input int r);
        int c;
        int err_before;
        int out_before;
        int acc_before;
        int drop_before;
        err_before  = errors_main + errors_mon;
        out_before  = out_total;
        acc_before  = sum_of(acc_cnt);
        drop_before = sum_of(drop_cnt);
        @(posedge rd_clk);
        drain_en <= (ROW_DRAIN[r] != 0);
        for (int i = 0; i < ROW_BURST[r]; i++) begin
            c = (ROW_CH[r] == RANDOM_CH) ? int'($urandom % NUM_CH) : ROW_CH[r];
            send_strobe(c, DATA_W'($urandom));
        end
        // with drain on, wait for every accepted sample to come out
        if (ROW_DRAIN[r] != 0) begin
            while (pending_total() > 0) begin
                @(posedge rd_clk);
            end
        end
        repeat (ROW_IDLE[r]) @(posedge wr_clk);
        check_flags();
        $display("row %0d: ch=%s burst=%0d drain=%0d accepted=%0d dropped=%0d outputs=%0d %s",
                 r, (ROW_CH[r] == RANDOM_CH) ? "rand" : $sformatf("%0d", ROW_CH[r]),
                 ROW_BURST[r], ROW_DRAIN[r], sum_of(acc_cnt) - acc_before,
                 sum_of(drop_cnt) - drop_before, out_total - out_before,
                 (errors_main + errors_mon == err_before) ? "pass" : "fail");
    endtask

    // output monitor checking order, data and service fairness
    always @(posedge rd_clk) begin
        int c;
        logic [DATA_W-1:0] exp_d;
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                rd_idx[i]   = 0;
                wait_cnt[i] = 0;
            end
            out_total  = 0;
            errors_mon = 0;
            prev_valid = 1'b0;
            prev_ch    = '0;
        end else begin
            if (out_valid) begin
                c = int'(out_ch);
                assert (pending(c) > 0) else begin
                    $display("ERROR time=%0t: output on channel %0d with no sample pending",
                             $time, c);
                    errors_mon++;
                end
                if (pending(c) > 0) begin
                    exp_d = model_q[c][rd_idx[c]];
                    errors_mon += int'(check_eq("out_data", int'(exp_d), int'(out_data)));
                    rd_idx[c]++;
                end
                out_total++;
                assert (!(prev_valid && prev_ch == out_ch)) else begin
                    $display("ERROR time=%0t: channel %0d served on two consecutive cycles",
                             $time, c);
                    errors_mon++;
                end
            end
            prev_valid = out_valid;
            prev_ch    = out_ch;
            for (int i = 0; i < NUM_CH; i++) begin
                if (drain_en && pending(i) > 0 && !(out_valid && out_ch == ch_t'(i))) begin
                    wait_cnt[i]++;
                end else begin
                    wait_cnt[i] = 0;
                end
                assert (wait_cnt[i] <= STARVE_LIMIT) else begin
                    $display("ERROR time=%0t: channel %0d waited %0d cycles without service",
                             $time, i, wait_cnt[i]);
                    errors_mon++;
                    wait_cnt[i] = 0;
                end
            end
        end
    end

    always @(posedge rd_clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("TIMEOUT: run did not finish within %0d rd_clk cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_ch       = '0;
        in_data     = '0;
        drain_en    = 1'b0;
        errors_main = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            acc_cnt[c]  = 0;
            drop_cnt[c] = 0;
        end
        cycle_limit = timeout_limit();
        void'($urandom(21));

        repeat (4) @(posedge rd_clk);
        rst_n <= 1'b1;
        @(posedge rd_clk);
        errors_main += int'(check_eq("out_valid", 0, int'(out_valid)));
        errors_main += int'(check_eq("ch_empty", (1 << NUM_CH) - 1, int'(ch_empty)));
        errors_main += int'(check_eq("drop_count", 0, int'(drop_count)));
        $display("reset: %s", (errors_main == 0) ? "pass" : "fail");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        errors_main += int'(check_eq("output count", sum_of(acc_cnt), out_total));
        $display("summary: rows=%0d accepted=%0d dropped=%0d outputs=%0d errors=%0d",
                 NUM_ROWS, sum_of(acc_cnt), sum_of(drop_cnt), out_total,
                 errors_main + errors_mon);
        if (errors_main + errors_mon == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cdc_collector_top.sv ====
`default_nettype none

module cdc_collector_top (
    input  logic                                                 wr_clk,
    input  logic                                                 rd_clk,
    input  logic                                                 rst_n,
    input  logic                                                 in_valid,
    input  fifo_types_pkg::ch_t                                  in_ch,
    input  logic [fifo_cfg_pkg::DATA_W-1:0]                      in_data,
    input  logic                                                 drain_en,
    output logic                                                 out_valid,
    output fifo_types_pkg::ch_t                                  out_ch,
    output logic [fifo_cfg_pkg::DATA_W-1:0]                      out_data,
    output logic [fifo_cfg_pkg::NUM_CH*fifo_cfg_pkg::DROP_W-1:0] drop_count,
    output logic [fifo_cfg_pkg::NUM_CH-1:0]                      ch_empty,
    output logic [fifo_cfg_pkg::NUM_CH-1:0]                      ch_almost_full,
    output logic [fifo_cfg_pkg::NUM_CH-1:0]                      ch_almost_empty
);

    import fifo_cfg_pkg::*;

    // write domain
    logic [NUM_CH-1:0]        fifo_wr_en;
    logic [DATA_W-1:0]        fifo_wr_data;
    logic [NUM_CH-1:0]        ch_full;

    // read domain
    logic [NUM_CH-1:0]        fifo_rd_en;
    logic [NUM_CH*DATA_W-1:0] fifo_rd_data;

    ingress_dispatch ingress_dispatch_i (
        .wr_clk       (wr_clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ch        (in_ch),
        .in_data      (in_data),
        .full         (ch_full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .drop_count   (drop_count)
    );

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        async_fifo async_fifo_i (
            .wr_clk       (wr_clk),
            .rd_clk       (rd_clk),
            .rst_n        (rst_n),
            .wr_en        (fifo_wr_en[c]),
            .wr_data      (fifo_wr_data),
            .rd_en        (fifo_rd_en[c]),
            .rd_data      (fifo_rd_data[c*DATA_W +: DATA_W]),
            .full         (ch_full[c]),
            .empty        (ch_empty[c]),
            .almost_full  (ch_almost_full[c]),
            .almost_empty (ch_almost_empty[c])
        );
    end

    egress_merge egress_merge_i (
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .drain_en   (drain_en),
        .empty      (ch_empty),
        .rd_data    (fifo_rd_data),
        .fifo_rd_en (fifo_rd_en),
        .out_valid  (out_valid),
        .out_ch     (out_ch),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

// ==== egress_merge.sv ====
`default_nettype none

module egress_merge (
    input  logic                                          rd_clk,
    input  logic                                          rst_n,
    input  logic                                          drain_en,
    input  logic [fifo_cfg_pkg::NUM_CH-1:0]               empty,
    input  logic [fifo_cfg_pkg::NUM_CH*fifo_cfg_pkg::DATA_W-1:0] rd_data,
    output logic [fifo_cfg_pkg::NUM_CH-1:0]               fifo_rd_en,
    output logic                                          out_valid,
    output fifo_types_pkg::ch_t                           out_ch,
    output logic [fifo_cfg_pkg::DATA_W-1:0]               out_data
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    merge_state_e      state;
    merge_state_e      state_next;
    ch_t               last_grant;
    ch_t               grant_ch;
    logic              grant_valid;
    logic              issue;
    logic [NUM_CH-1:0] eligible;

    // channel read last cycle is skipped
    always_comb begin
        eligible = ~empty;
        if (state == MRG_ISSUE) begin
            eligible[last_grant] = 1'b0;
        end
    end

    // round-robin search starting just after the last grant
    always_comb begin
        ch_t cand;
        grant_valid = 1'b0;
        grant_ch    = last_grant;
        for (int off = 1; off <= NUM_CH; off++) begin
            cand = ch_t'(last_grant + off);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_ch    = cand;
            end
        end
    end

    assign issue = drain_en && grant_valid;

    always_comb begin
        fifo_rd_en           = '0;
        fifo_rd_en[grant_ch] = issue;
    end

    assign state_next = issue ? MRG_ISSUE : MRG_IDLE;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= MRG_IDLE;
            // first search then starts at channel 0
            last_grant <= ch_t'(NUM_CH - 1);
        end else begin
            state <= state_next;
            if (issue) begin
                last_grant <= grant_ch;
            end
        end
    end

    // FIFO rd_data was registered on the issuing edge
    assign out_valid = (state == MRG_ISSUE);
    assign out_ch    = last_grant;
    assign out_data  = rd_data[last_grant*DATA_W +: DATA_W];

    a_rd_en_onehot0: assert property (
        @(posedge rd_clk) disable iff (!rst_n) $onehot0(fifo_rd_en)
    ) else $error("egress_merge: fifo_rd_en not one-hot");

endmodule

`default_nettype wire

// ==== ingress_dispatch.sv ====
`default_nettype none

module ingress_dispatch (
    input  logic                                                 wr_clk,
    input  logic                                                 rst_n,
    input  logic                                                 in_valid,
    input  fifo_types_pkg::ch_t                                  in_ch,
    input  logic [fifo_cfg_pkg::DATA_W-1:0]                      in_data,
    input  logic [fifo_cfg_pkg::NUM_CH-1:0]                      full,
    output logic [fifo_cfg_pkg::NUM_CH-1:0]                      fifo_wr_en,
    output logic [fifo_cfg_pkg::DATA_W-1:0]                      fifo_wr_data,
    output logic [fifo_cfg_pkg::NUM_CH*fifo_cfg_pkg::DROP_W-1:0] drop_count
);

    import fifo_cfg_pkg::*;

    logic [NUM_CH-1:0] ch_sel;
    logic [NUM_CH-1:0] drop_hit;
    logic [DROP_W-1:0] drop_cnt [NUM_CH];

    // one-hot decode of the strobe's channel
    always_comb begin
        ch_sel        = '0;
        ch_sel[in_ch] = in_valid;
    end

    // write goes out on the same edge that samples in_valid
    assign fifo_wr_en   = ch_sel & ~full;
    assign drop_hit     = ch_sel & full;
    assign fifo_wr_data = in_data;

    for (genvar c = 0; c < NUM_CH; c++) begin : g_drop
        // saturating drop counter
        always_ff @(posedge wr_clk or negedge rst_n) begin
            if (!rst_n) begin
                drop_cnt[c] <= '0;
            end else if (drop_hit[c] && (drop_cnt[c] != '1)) begin
                drop_cnt[c] <= drop_cnt[c] + 1'b1;
            end
        end

        assign drop_count[c*DROP_W +: DROP_W] = drop_cnt[c];
    end

    // at most one FIFO is written per strobe
    a_wr_en_onehot0: assert property (
        @(posedge wr_clk) disable iff (!rst_n) $onehot0(fifo_wr_en)
    ) else $error("ingress_dispatch: fifo_wr_en not one-hot");

endmodule

`default_nettype wire

// ==== async_fifo.sv ====
`default_nettype none

module async_fifo (
    input  logic                            wr_clk,
    input  logic                            rd_clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [fifo_cfg_pkg::DATA_W-1:0] wr_data,
    input  logic                            rd_en,
    output logic [fifo_cfg_pkg::DATA_W-1:0] rd_data,
    output logic                            full,
    output logic                            empty,
    output logic                            almost_full,
    output logic                            almost_empty
);

    import fifo_cfg_pkg::*;
    import fifo_types_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];

    // write domain
    ptr_t wr_ptr;
    ptr_t wr_gray;
    ptr_t rd_gray_s1;
    ptr_t rd_gray_s2;
    ptr_t rd_ptr_wr;
    ptr_t wr_fill;

    // read domain
    ptr_t rd_ptr;
    ptr_t rd_gray;
    ptr_t wr_gray_s1;
    ptr_t wr_gray_s2;
    ptr_t wr_ptr_rd;
    ptr_t rd_fill;

    function automatic ptr_t gray_to_bin(input ptr_t g);
        ptr_t b;
        b[PTR_W-1] = g[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    function automatic ptr_t bin_to_gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // storage, written on wr_clk
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // write pointer, its Gray copy and the read pointer synchroniser
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // pointer moves by at most one per cycle, so one Gray bit flips
            wr_gray    <= bin_to_gray(wr_ptr);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // read data is valid the cycle after rd_en
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // read pointer, its Gray copy and the write pointer synchroniser
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rd_gray    <= bin_to_gray(rd_ptr);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // write-side flags, pessimistic by the sync latency
    assign rd_ptr_wr   = gray_to_bin(rd_gray_s2);
    assign wr_fill     = wr_ptr - rd_ptr_wr;
    assign full        = (ptr_t'(wr_ptr + 1'b1) == rd_ptr_wr);
    assign almost_full = (wr_fill >= ptr_t'(ALMOST_FULL_THRESH));

    // read-side flags
    assign wr_ptr_rd    = gray_to_bin(wr_gray_s2);
    assign rd_fill      = wr_ptr_rd - rd_ptr;
    assign empty        = (rd_ptr == wr_ptr_rd);
    assign almost_empty = (rd_fill <= ptr_t'(ALMOST_EMPTY_THRESH));

    // the dispatcher gates writes against full, so one arriving here is an upstream bug
    a_no_write_when_full: assert property (
        @(posedge wr_clk) disable iff (!rst_n) wr_en |-> !full
    ) else $error("async_fifo: write while full");

    // likewise the merger only reads a channel it sees as non-empty
    a_no_read_when_empty: assert property (
        @(posedge rd_clk) disable iff (!rst_n) rd_en |-> !empty
    ) else $error("async_fifo: read while empty");

endmodule

`default_nettype wire

// ==== fifo_types_pkg.sv ====
`default_nettype none

package fifo_types_pkg;

    // channel index carried with each sample
    typedef logic [$clog2(fifo_cfg_pkg::NUM_CH)-1:0] ch_t;

    // FIFO pointer, used for both binary and Gray copies
    typedef logic [fifo_cfg_pkg::PTR_W-1:0] ptr_t;

    // merger state
    // MRG_ISSUE means a read was issued last cycle and its data is on rd_data now
    typedef enum logic {
        MRG_IDLE,
        MRG_ISSUE
    } merge_state_e;

endpackage

`default_nettype wire

// ==== fifo_cfg_pkg.sv ====
`default_nettype none

package fifo_cfg_pkg;

    // number of collector channels
    // keep this a power of two so channel indices wrap cleanly
    localparam int NUM_CH = 4;

    // sample payload width
    localparam int DATA_W = 8;

    // memory entries per FIFO, one slot stays unused
    localparam int FIFO_DEPTH = 16;

    // binary pointer width
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // write-side fill count at or above this raises almost_full
    localparam int ALMOST_FULL_THRESH = 12;

    // read-side fill count at or below this raises almost_empty
    localparam int ALMOST_EMPTY_THRESH = 2;

    // width of each per-channel drop counter, saturating
    localparam int DROP_W = 8;

endpackage

`default_nettype wire
